// File: flash_audio_player.f
src/player_pkg.sv
src/panel_pkg.sv
src/flash_req_if.sv
src/speed_control.sv
src/sample_sequencer.sv
src/flash_reader.sv
src/hex_display.sv
src/flash_audio_player.sv
tests/flash_model.sv
tests/tb_flash_audio_player.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it.
# The exit status is non-zero when the build or the simulation fails.

set -u
cd "$(dirname "$0")" || exit 1

TOP=tb_flash_audio_player
BUILD_DIR=obj_dir

verilator --binary --timing --assert -j 0 \
  --top-module "$TOP" --Mdir "$BUILD_DIR" \
  -f flash_audio_player.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

"./$BUILD_DIR/V$TOP"
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

echo "Simulation completed"

// File: src/flash_audio_player.sv
`timescale 1ns/100ps

module flash_audio_player
  import player_pkg::*;
  import panel_pkg::*;
#(
  parameter int SAMPLE_DIV_DEFAULT = 1136,
  parameter int SPEED_STEP         = 100,
  parameter int MIN_DIV            = 64,
  parameter int REPEAT_CYCLES      = 5000000,
  parameter int READ_WAIT          = 4,
  parameter int LAST_WORD          = 'h7FFFF,
  parameter int REFRESH_CYCLES     = 25000000
)
(
  input  logic                       CLK_50M,
  input  logic                       arst_n,
  input  logic [3:0]                 key_n,
  input  logic                       play,
  input  logic                       reverse,
  output byte_addr_t                 fl_addr,
  input  flash_byte_t                fl_dq,
  output logic                       fl_ce_n,
  output logic                       fl_oe_n,
  output logic                       fl_we_n,
  output logic                       fl_rst_n,
  output sample_t                    sample,
  output logic                       sample_valid,
  output segments_t [NUM_DIGITS-1:0] hex_segments
);

  logic       restart;
  div_count_t div_count;

  flash_req_if req_if ();

  // ========================================================================
  // Keys and divider
  // ========================================================================

  speed_control #(
    .SAMPLE_DIV_DEFAULT (SAMPLE_DIV_DEFAULT),
    .SPEED_STEP         (SPEED_STEP),
    .MIN_DIV            (MIN_DIV),
    .REPEAT_CYCLES      (REPEAT_CYCLES)
  ) u_speed_control (
    .CLK_50M   (CLK_50M),
    .arst_n    (arst_n),
    .key_n     (key_n),
    .restart   (restart),
    .div_count (div_count)
  );

  // ========================================================================
  // Playback path
  // ========================================================================

  sample_sequencer #(
    .LAST_WORD (LAST_WORD)
  ) u_sample_sequencer (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .play         (play),
    .reverse      (reverse),
    .restart      (restart),
    .div_count    (div_count),
    .req          (req_if),
    .sample       (sample),
    .sample_valid (sample_valid)
  );

  flash_reader #(
    .READ_WAIT (READ_WAIT)
  ) u_flash_reader (
    .CLK_50M  (CLK_50M),
    .arst_n   (arst_n),
    .req      (req_if),
    .fl_addr  (fl_addr),
    .fl_dq    (fl_dq),
    .fl_ce_n  (fl_ce_n),
    .fl_oe_n  (fl_oe_n),
    .fl_we_n  (fl_we_n),
    .fl_rst_n (fl_rst_n)
  );

  // Divider readout on the eight digits
  hex_display #(
    .REFRESH_CYCLES (REFRESH_CYCLES)
  ) u_hex_display (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .div_count    (div_count),
    .hex_segments (hex_segments)
  );

endmodule

// File: src/flash_reader.sv
`timescale 1ns/100ps

module flash_reader
  import player_pkg::*;
#(
  parameter int READ_WAIT = 4
)
(
  input  logic        CLK_50M,
  input  logic        arst_n,
  flash_req_if.server req,
  output byte_addr_t  fl_addr,
  input  flash_byte_t fl_dq,
  output logic        fl_ce_n,
  output logic        fl_oe_n,
  output logic        fl_we_n,
  output logic        fl_rst_n
);

  localparam int WAIT_W = $clog2(READ_WAIT + 1);

  reader_state_t     state;
  logic [WAIT_W-1:0] wait_cnt;
  logic              wait_end;
  logic              access;
  word_addr_t        addr_q;
  flash_byte_t       byte_lo;
  flash_byte_t       byte_hi;

  assign wait_end = wait_cnt == WAIT_W'(READ_WAIT - 1);

  // Even byte first, then odd byte, READ_WAIT clocks each
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state    <= RD_IDLE;
      wait_cnt <= '0;
    end
    else
    begin
      case (state)
        RD_IDLE:
        begin
          wait_cnt <= '0;
          if (req.start)
            state <= RD_LOW;
        end
        RD_LOW, RD_HIGH:
        begin
          if (wait_end)
          begin
            wait_cnt <= '0;
            state    <= (state == RD_LOW) ? RD_HIGH : RD_DONE;
          end
          else
            wait_cnt <= wait_cnt + 1'b1;
        end
        RD_DONE:
          state <= RD_IDLE;
        default:
          state <= RD_IDLE;
      endcase
    end
  end

  // Request address and bytes as they come off the bus
  always_ff @(posedge CLK_50M)
  begin
    if (state == RD_IDLE && req.start)
      addr_q <= req.addr;
    if (state == RD_LOW && wait_end)
      byte_lo <= fl_dq;
    if (state == RD_HIGH && wait_end)
      byte_hi <= fl_dq;
  end

  // Flash comes out of reset with the design
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      fl_rst_n <= 1'b0;
    else
      fl_rst_n <= 1'b1;
  end

  assign access  = (state == RD_LOW) || (state == RD_HIGH);
  assign fl_ce_n = ~access;
  assign fl_oe_n = ~access;
  assign fl_we_n = 1'b1;
  assign fl_addr = {addr_q, state == RD_HIGH};

  assign req.done = state == RD_DONE;
  assign req.data = {byte_hi, byte_lo};

endmodule

// File: src/flash_req_if.sv
`timescale 1ns/100ps

interface flash_req_if import player_pkg::*; ();

  // One-cycle strobes, no back-pressure
  logic       start;
  word_addr_t addr;
  logic       done;
  sample_t    data;

  modport requester (
    output start,
    output addr,
    input  done,
    input  data
  );

  modport server (
    input  start,
    input  addr,
    output done,
    output data
  );

endinterface

// File: src/hex_display.sv
`timescale 1ns/100ps

module hex_display
  import player_pkg::*;
  import panel_pkg::*;
#(
  parameter int REFRESH_CYCLES = 25000000
)
(
  input  logic                        CLK_50M,
  input  logic                        arst_n,
  input  div_count_t                  div_count,
  output segments_t [NUM_DIGITS-1:0]  hex_segments
);

  localparam int REF_W = $clog2(REFRESH_CYCLES + 1);

  logic [REF_W-1:0]        refresh_cnt;
  logic                    refresh_due;
  div_count_t              shown_div;
  logic [4*NUM_DIGITS-1:0] shown_wide;

  assign refresh_due = refresh_cnt == REF_W'(REFRESH_CYCLES - 1);

  // Counter starts due so the divider is taken right after reset
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      refresh_cnt <= REF_W'(REFRESH_CYCLES - 1);
      shown_div   <= '0;
    end
    else if (refresh_due)
    begin
      refresh_cnt <= '0;
      shown_div   <= div_count;
    end
    else
      refresh_cnt <= refresh_cnt + 1'b1;
  end

  // Upper digits stay at 0
  assign shown_wide = (4*NUM_DIGITS)'(shown_div);

  always_comb
  begin
    hex_digit_t digit;
    for (int i = 0; i < NUM_DIGITS; i++)
    begin
      digit           = shown_wide[4*i +: 4];
      hex_segments[i] = SEG_TABLE[digit];
    end
  end

endmodule

// File: src/panel_pkg.sv
package panel_pkg;

  localparam int NUM_DIGITS = 8;

  typedef logic [3:0] hex_digit_t;

  // Active low, segment a in bit 0 up to g in bit 6
  typedef logic [6:0] segments_t;

  // Patterns for 0 to F
  localparam segments_t SEG_TABLE [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30,
    7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03,
    7'h46, 7'h21, 7'h06, 7'h0E
  };

endpackage

// File: src/player_pkg.sv
package player_pkg;

  // ========================================================================
  // Data path widths
  // ========================================================================

  localparam int SAMPLE_W    = 16;
  localparam int WORD_ADDR_W = 21;
  localparam int FLASH_DQ_W  = 8;
  localparam int DIV_W       = 16;

  // One audio sample as stored in flash
  typedef logic [SAMPLE_W-1:0] sample_t;

  // Word address, one word per sample
  typedef logic [WORD_ADDR_W-1:0] word_addr_t;

  // Byte address on the flash pins, bit 0 picks low or high byte
  typedef logic [WORD_ADDR_W:0] byte_addr_t;

  typedef logic [FLASH_DQ_W-1:0] flash_byte_t;

  // Sample tick comes every div_count+1 clocks
  typedef logic [DIV_W-1:0] div_count_t;

  // ========================================================================
  // State machines
  // ========================================================================

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_LOW,
    RD_HIGH,
    RD_DONE
  } reader_state_t;

  typedef enum logic {
    SEQ_WAIT_TICK,
    SEQ_WAIT_READ
  } seq_state_t;

endpackage

// File: src/sample_sequencer.sv
`timescale 1ns/100ps

module sample_sequencer
  import player_pkg::*;
#(
  parameter int LAST_WORD = 'h7FFFF
)
(
  input  logic           CLK_50M,
  input  logic           arst_n,
  input  logic           play,
  input  logic           reverse,
  input  logic           restart,
  input  div_count_t     div_count,
  flash_req_if.requester req,
  output sample_t        sample,
  output logic           sample_valid
);

  localparam word_addr_t LAST_ADDR = word_addr_t'(LAST_WORD);

  seq_state_t state;
  div_count_t tick_cnt;
  logic       tick;
  word_addr_t word_addr;
  word_addr_t next_addr;
  word_addr_t first_addr;
  logic       restart_pending;
  logic       restart_req;
  logic       read_done;

  // ========================================================================
  // Sample tick
  // ========================================================================

  // Compare with >= so a smaller divider takes effect at once
  assign tick = tick_cnt >= div_count;

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      tick_cnt <= '0;
    else if (tick)
      tick_cnt <= '0;
    else
      tick_cnt <= tick_cnt + 1'b1;
  end

  // ========================================================================
  // Read sequencing and address walk
  // ========================================================================

  assign req.start = tick && play && (state == SEQ_WAIT_TICK);
  assign req.addr  = word_addr;

  assign read_done   = (state == SEQ_WAIT_READ) && req.done;
  assign restart_req = restart | restart_pending;
  assign first_addr  = reverse ? LAST_ADDR : '0;

  always_comb
  begin
    if (reverse)
      next_addr = (word_addr == '0) ? LAST_ADDR : word_addr - 1'b1;
    else
      next_addr = (word_addr == LAST_ADDR) ? '0 : word_addr + 1'b1;
  end

  // A restart during a read waits for its done
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state           <= SEQ_WAIT_TICK;
      word_addr       <= '0;
      restart_pending <= 1'b0;
    end
    else
    begin
      case (state)
        SEQ_WAIT_TICK:
        begin
          if (req.start)
          begin
            state           <= SEQ_WAIT_READ;
            restart_pending <= restart_req;
          end
          else if (restart_req)
          begin
            word_addr       <= first_addr;
            restart_pending <= 1'b0;
          end
        end
        SEQ_WAIT_READ:
        begin
          if (req.done)
          begin
            state           <= SEQ_WAIT_TICK;
            word_addr       <= restart_req ? first_addr : next_addr;
            restart_pending <= 1'b0;
          end
          else
            restart_pending <= restart_req;
        end
        default:
          state <= SEQ_WAIT_TICK;
      endcase
    end
  end

  // Output word and its valid strobe
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      sample       <= '0;
      sample_valid <= 1'b0;
    end
    else
    begin
      sample_valid <= read_done;
      if (read_done)
        sample <= req.data;
    end
  end

endmodule

// File: src/speed_control.sv
`timescale 1ns/100ps

module speed_control
  import player_pkg::*;
#(
  parameter int SAMPLE_DIV_DEFAULT = 1136,
  parameter int SPEED_STEP         = 100,
  parameter int MIN_DIV            = 64,
  parameter int REPEAT_CYCLES      = 5000000
)
(
  input  logic       CLK_50M,
  input  logic       arst_n,
  input  logic [3:0] key_n,
  output logic       restart,
  output div_count_t div_count
);

  localparam int REP_W = $clog2(REPEAT_CYCLES + 1);

  logic [3:0]       key_meta_n;
  logic [3:0]       key_sync_n;
  logic             restart_prev;
  logic             up_pressed;
  logic             down_pressed;
  logic             speed_reset_pressed;
  logic             restart_pressed;
  logic             hold_one;
  logic             step_fire;
  logic             up_ok;
  logic [REP_W-1:0] repeat_cnt;
  logic [DIV_W:0]   div_dec;
  logic [DIV_W:0]   div_inc;

  // Two flop synchronizer, keys idle high
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      key_meta_n <= '1;
      key_sync_n <= '1;
    end
    else
    begin
      key_meta_n <= key_n;
      key_sync_n <= key_meta_n;
    end
  end

  assign up_pressed          = ~key_sync_n[0];
  assign down_pressed        = ~key_sync_n[1];
  assign speed_reset_pressed = ~key_sync_n[2];
  assign restart_pressed     = ~key_sync_n[3];

  // ========================================================================
  // Auto-repeat for up and down
  // ========================================================================

  // Both keys held at once count as no key
  assign hold_one  = up_pressed ^ down_pressed;
  assign step_fire = hold_one && (repeat_cnt == REP_W'(REPEAT_CYCLES - 1));

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      repeat_cnt <= '0;
    else if (!hold_one || step_fire)
      repeat_cnt <= '0;
    else
      repeat_cnt <= repeat_cnt + 1'b1;
  end

  // Bounds for one step either way
  assign div_dec = {1'b0, div_count} - (DIV_W + 1)'(SPEED_STEP);
  assign div_inc = {1'b0, div_count} + (DIV_W + 1)'(SPEED_STEP);
  assign up_ok   = int'(div_count) >= MIN_DIV + SPEED_STEP;

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      div_count <= div_count_t'(SAMPLE_DIV_DEFAULT);
    else if (speed_reset_pressed)
      div_count <= div_count_t'(SAMPLE_DIV_DEFAULT);
    else if (step_fire && up_pressed && up_ok)
      div_count <= div_dec[DIV_W-1:0];
    else if (step_fire && down_pressed && !div_inc[DIV_W])
      div_count <= div_inc[DIV_W-1:0];
  end

  // Restart fires once per press
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      restart_prev <= 1'b0;
    else
      restart_prev <= restart_pressed;
  end

  assign restart = restart_pressed & ~restart_prev;

endmodule

// File: tests/flash_model.sv
`timescale 1ns/100ps

module flash_model
  import player_pkg::*;
(
  input  byte_addr_t  fl_addr,
  input  logic        fl_ce_n,
  input  logic        fl_oe_n,
  output flash_byte_t fl_dq
);

  // Every byte holds its low address bits XOR A5
  // Bus idles high when the chip is not read
  assign fl_dq = (!fl_ce_n && !fl_oe_n) ? (fl_addr[7:0] ^ 8'hA5) : 8'hFF;

endmodule

// File: tests/tb_flash_audio_player.sv
`timescale 1ns/100ps

module tb_flash_audio_player;

  localparam int CLK_PERIOD     = 20;
  localparam int RESET_CYCLES   = 5;
  localparam int SETTLE_CYCLES  = 8;
  localparam int DIV_DEFAULT    = 200;
  localparam int SPEED_STEP     = 20;
  localparam int MIN_DIV        = 40;
  localparam int REPEAT_CYCLES  = 50;
  localparam int READ_WAIT      = 2;
  localparam int LAST_WORD      = 15;
  localparam int REFRESH_CYCLES = 30;

  localparam logic [3:0] KEY_IDLE    = 4'b1111;
  localparam logic [3:0] KEY_UP      = 4'b1110;
  localparam logic [3:0] KEY_DOWN    = 4'b1101;
  localparam logic [3:0] KEY_SPD_RST = 4'b1011;
  localparam logic [3:0] KEY_RESTART = 4'b0111;

  typedef struct packed {
    logic       play;
    logic       reverse;
    logic [3:0] key_n;
    int         hold;
    int         min_count;
    int         max_count;
    int         exp_div;
    logic       check_period;
  } row_t;

  logic            CLK_50M;
  logic            arst_n;
  logic [3:0]      key_n;
  logic            play;
  logic            reverse;
  logic [21:0]     fl_addr;
  logic [7:0]      fl_dq;
  logic            fl_ce_n;
  logic            fl_oe_n;
  logic            fl_we_n;
  logic            fl_rst_n;
  logic [15:0]     sample;
  logic            sample_valid;
  logic [7:0][6:0] hex_segments;

  row_t rows[$];
  bit   table_ready = 1'b0;

  // Shared between the row driver and the sample monitor
  int   cycle            = 0;
  int   row_idx          = -1;
  int   exp_div          = DIV_DEFAULT;
  logic period_on        = 1'b0;
  int   restart_cnt      = 0;
  int   restart_target   = 0;
  int   restart_done_cnt = 0;
  int   total_count      = 0;
  int   ref_addr         = 0;
  int   last_valid_cycle = 0;
  int   last_valid_row   = -1;
  logic rev_prev         = 1'b0;
  logic valid_prev       = 1'b0;
  logic [15:0] expected_word;

  flash_audio_player #(
    .SAMPLE_DIV_DEFAULT (DIV_DEFAULT),
    .SPEED_STEP         (SPEED_STEP),
    .MIN_DIV            (MIN_DIV),
    .REPEAT_CYCLES      (REPEAT_CYCLES),
    .READ_WAIT          (READ_WAIT),
    .LAST_WORD          (LAST_WORD),
    .REFRESH_CYCLES     (REFRESH_CYCLES)
  ) uut (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .key_n        (key_n),
    .play         (play),
    .reverse      (reverse),
    .fl_addr      (fl_addr),
    .fl_dq        (fl_dq),
    .fl_ce_n      (fl_ce_n),
    .fl_oe_n      (fl_oe_n),
    .fl_we_n      (fl_we_n),
    .fl_rst_n     (fl_rst_n),
    .sample       (sample),
    .sample_valid (sample_valid),
    .hex_segments (hex_segments)
  );

  flash_model u_flash (
    .fl_addr (fl_addr),
    .fl_ce_n (fl_ce_n),
    .fl_oe_n (fl_oe_n),
    .fl_dq   (fl_dq)
  );

  // ==========================================================================
  // Reference rules
  // ==========================================================================

  function automatic logic [7:0] flash_byte(input logic [21:0] byte_addr);
    return byte_addr[7:0] ^ 8'hA5;
  endfunction

  // High byte from the odd address, low byte from the even one
  function automatic logic [15:0] word_sample(input int word);
    logic [21:0] even_addr;
    even_addr = 22'(word * 2);
    return {flash_byte(even_addr + 22'd1), flash_byte(even_addr)};
  endfunction

  // Lit segments gfedcba, inverted for the active-low outputs
  function automatic logic [6:0] segment_pattern(input logic [3:0] digit);
    logic [6:0] lit;
    case (digit)
      4'h0: lit = 7'h3F;
      4'h1: lit = 7'h06;
      4'h2: lit = 7'h5B;
      4'h3: lit = 7'h4F;
      4'h4: lit = 7'h66;
      4'h5: lit = 7'h6D;
      4'h6: lit = 7'h7D;
      4'h7: lit = 7'h07;
      4'h8: lit = 7'h7F;
      4'h9: lit = 7'h6F;
      4'hA: lit = 7'h77;
      4'hB: lit = 7'h7C;
      4'hC: lit = 7'h39;
      4'hD: lit = 7'h5E;
      4'hE: lit = 7'h79;
      default: lit = 7'h71;
    endcase
    return ~lit;
  endfunction

  function automatic logic [7:0][6:0] display_pattern(input int div);
    logic [7:0][6:0] segs;
    logic [31:0]     value;
    value = 32'(div);
    for (int i = 0; i < 8; i++)
      segs[i] = segment_pattern(value[4*i +: 4]);
    return segs;
  endfunction

  // ==========================================================================
  // Failure reporting and checks
  // ==========================================================================

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string what);
    fail_run($sformatf("MISMATCH at %0t: %s", $time, what));
  endtask

  task automatic check_display(input int div);
    logic [7:0][6:0] expected;
    expected = display_pattern(div);
    assert (hex_segments == expected)
      else report_mismatch($sformatf("display %h, expected %h for divider %0d",
                                     hex_segments, expected, div));
  endtask

  task automatic check_reset_state();
    assert (fl_ce_n && fl_oe_n && fl_we_n && fl_rst_n)
      else report_mismatch($sformatf("flash pins ce_n %b oe_n %b we_n %b rst_n %b",
                                     fl_ce_n, fl_oe_n, fl_we_n, fl_rst_n));
    assert (!sample_valid && sample == 16'h0000)
      else report_mismatch($sformatf("after reset valid %b sample %h",
                                     sample_valid, sample));
  endtask

  task automatic add_row(input logic play_in, input logic rev_in, input logic [3:0] keys,
                         input int hold, input int min_count, input int max_count,
                         input int div, input logic period);
    row_t row;
    row.play         = play_in;
    row.reverse      = rev_in;
    row.key_n        = keys;
    row.hold         = hold;
    row.min_count    = min_count;
    row.max_count    = max_count;
    row.exp_div      = div;
    row.check_period = period;
    rows.push_back(row);
  endtask

  // play, reverse, keys, hold, sample count range, divider, period check
  task automatic load_table();
    add_row(1'b1, 1'b0, KEY_IDLE,    3600, 17, 18, DIV_DEFAULT, 1'b1);
    add_row(1'b0, 1'b0, KEY_IDLE,     500,  0,  1, DIV_DEFAULT, 1'b0);
    add_row(1'b1, 1'b0, KEY_IDLE,    1000,  4,  5, DIV_DEFAULT, 1'b1);
    add_row(1'b0, 1'b1, KEY_RESTART,  300,  0,  1, DIV_DEFAULT, 1'b0);
    add_row(1'b1, 1'b1, KEY_IDLE,    3600, 17, 18, DIV_DEFAULT, 1'b1);
    add_row(1'b0, 1'b0, KEY_IDLE,     100,  0,  1, DIV_DEFAULT, 1'b0);
    add_row(1'b1, 1'b0, KEY_IDLE,     600,  2,  3, DIV_DEFAULT, 1'b1);
    // Three repeat steps down to 140
    add_row(1'b1, 1'b0, KEY_UP,       190,  0,  2, DIV_DEFAULT - 3*SPEED_STEP, 1'b0);
    add_row(1'b1, 1'b0, KEY_IDLE,    1500, 10, 11, DIV_DEFAULT - 3*SPEED_STEP, 1'b1);
    add_row(1'b1, 1'b0, KEY_DOWN,      90,  0,  1, DIV_DEFAULT - 2*SPEED_STEP, 1'b0);
    add_row(1'b1, 1'b0, KEY_IDLE,     800,  4,  5, DIV_DEFAULT - 2*SPEED_STEP, 1'b1);
    // Ten steps asked, divider stops at the floor
    add_row(1'b1, 1'b0, KEY_UP,       540,  4, 14, MIN_DIV, 1'b0);
    add_row(1'b1, 1'b0, KEY_IDLE,     400,  9, 10, MIN_DIV, 1'b1);
    add_row(1'b1, 1'b0, KEY_UP,        90,  2,  3, MIN_DIV, 1'b1);
    add_row(1'b1, 1'b0, KEY_SPD_RST,   60,  0,  2, DIV_DEFAULT, 1'b0);
    add_row(1'b1, 1'b0, KEY_IDLE,    1000,  4,  5, DIV_DEFAULT, 1'b1);
  endtask

  // ==========================================================================
  // Clock, watchdog and sample monitor
  // ==========================================================================

  initial
  begin
    CLK_50M = 1'b0;
    forever #(CLK_PERIOD / 2) CLK_50M = ~CLK_50M;
  end

  always @(posedge CLK_50M)
    cycle <= cycle + 1;

  initial
  begin
    int total;
    wait (table_ready);
    total = RESET_CYCLES + REFRESH_CYCLES + 4;
    foreach (rows[i])
      total = total + rows[i].hold + 2;
    total = total * 12 / 10;
    repeat (total) @(posedge CLK_50M);
    fail_run($sformatf("Watchdog timeout: run did not end within %0d cycles", total));
  end

  // Checks every sample against the address walk of the reference
  always @(negedge CLK_50M)
  begin
    if (restart_done_cnt != restart_cnt)
    begin
      ref_addr         = restart_target;
      restart_done_cnt = restart_cnt;
    end
    // Flash pins carry the word that the next sample comes from
    if (arst_n && !fl_ce_n)
      assert (fl_addr[21:1] == 21'(ref_addr))
        else report_mismatch($sformatf("flash address %h, expected word %0d",
                                       fl_addr, ref_addr));
    if (arst_n && sample_valid)
    begin
      expected_word = word_sample(ref_addr);
      assert (sample == expected_word)
        else report_mismatch($sformatf("word %0d read as %h, expected %h",
                                       ref_addr, sample, expected_word));
      assert (!valid_prev)
        else report_mismatch("sample_valid high for more than one cycle");
      if (period_on && last_valid_row == row_idx)
        assert (cycle - last_valid_cycle == exp_div + 1)
          else report_mismatch($sformatf("sample period %0d, expected %0d",
                                         cycle - last_valid_cycle, exp_div + 1));
      last_valid_cycle = cycle;
      last_valid_row   = row_idx;
      total_count      = total_count + 1;
      // Direction as the DUT saw it on the previous edge
      if (rev_prev)
        ref_addr = (ref_addr == 0) ? LAST_WORD : ref_addr - 1;
      else
        ref_addr = (ref_addr == LAST_WORD) ? 0 : ref_addr + 1;
    end
    valid_prev = sample_valid;
    rev_prev   = reverse;
  end

  // ==========================================================================
  // Stimulus
  // ==========================================================================

  initial
  begin
    row_t cur;
    int   row_base;
    int   settle_base;
    int   row_count;

    arst_n  <= 1'b0;
    key_n   <= KEY_IDLE;
    play    <= 1'b0;
    reverse <= 1'b0;
    load_table();
    table_ready = 1'b1;

    repeat (RESET_CYCLES) @(posedge CLK_50M);
    arst_n <= 1'b1;
    repeat (2) @(posedge CLK_50M);
    @(negedge CLK_50M);
    check_reset_state();
    repeat (REFRESH_CYCLES + 1) @(posedge CLK_50M);
    @(negedge CLK_50M);
    check_display(DIV_DEFAULT);
    @(posedge CLK_50M);

    for (int r = 0; r < rows.size(); r++)
    begin
      cur       = rows[r];
      row_idx   = r;
      exp_div   = cur.exp_div;
      period_on = cur.check_period;
      play    <= cur.play;
      reverse <= cur.reverse;
      key_n   <= cur.key_n;
      row_base = total_count;
      repeat (SETTLE_CYCLES) @(posedge CLK_50M);
      // A read issued just before a pause has landed by now
      settle_base = total_count;
      repeat (cur.hold - SETTLE_CYCLES) @(posedge CLK_50M);

      row_count = total_count - row_base;
      assert (row_count >= cur.min_count && row_count <= cur.max_count)
        else report_mismatch($sformatf("row %0d gave %0d samples, expected %0d to %0d",
                                       r, row_count, cur.min_count, cur.max_count));
      if (!cur.play)
        assert (total_count == settle_base)
          else report_mismatch($sformatf("row %0d paused but gave %0d samples",
                                         r, total_count - settle_base));
      @(negedge CLK_50M);
      check_display(cur.exp_div);
      @(posedge CLK_50M);

      // Restart lands on the first word of the current direction
      if (!cur.key_n[3])
      begin
        restart_target = cur.reverse ? LAST_WORD : 0;
        restart_cnt    = restart_cnt + 1;
      end
    end

    $display("*** PASSED ***");
    $finish;
  end

endmodule
